/* sq_pkg.sv */
// ######################################
// Store path shared definitions
// Widths, the dual-view line address and
// the line and mask types
// ######################################

`default_nettype none

package sq_pkg;

	// Byte address and line geometry
	localparam int ADDR_WIDTH = 8;
	localparam int LINE_BYTES = 8;
	localparam int OFFSET_WIDTH = 3;
	localparam int LINE_IDX_WIDTH = 5;
	localparam int NUM_LINES = 2 ** LINE_IDX_WIDTH;

	typedef logic [LINE_IDX_WIDTH - 1:0] line_idx_t;
	typedef logic [OFFSET_WIDTH - 1:0] line_offset_t;
	typedef logic [LINE_BYTES * 8 - 1:0] line_data_t;
	typedef logic [LINE_BYTES - 1:0] byte_mask_t;

	// The same address word seen either as a plain byte address or split
	// into the line it falls in and the byte within that line
	typedef union packed {
		logic [ADDR_WIDTH - 1:0] raw;
		struct packed {
			line_idx_t line_idx;
			line_offset_t offset;
		} fields;
	} line_addr_u;

endpackage

`default_nettype wire

/* rr_arbiter.sv */
// ######################################
// Round-robin arbiter
// Picks the first requester after the last
// winner and holds it until acknowledged
// ######################################

`timescale 1ns/1ns
`default_nettype none

module rr_arbiter #(
	parameter int NUM_THREADS = 4
) (
	input logic clk,
	input logic reset,
	input logic [NUM_THREADS - 1:0] request,
	input logic advance,
	output logic [NUM_THREADS - 1:0] grant_oh,
	output logic [$clog2(NUM_THREADS) - 1:0] grant_idx
);

	localparam int IDX_WIDTH = $clog2(NUM_THREADS);

	logic [IDX_WIDTH - 1:0] last_idx;
	logic held;
	logic [IDX_WIDTH - 1:0] held_idx;
	logic [NUM_THREADS - 1:0] search_oh;
	logic [IDX_WIDTH - 1:0] search_idx;

	// Scan forward from the slot after the last winner, wrapping around
	always_comb
	begin
		int candidate;
		logic found;
		search_oh = '0;
		search_idx = '0;
		found = 1'b0;
		for (int i = 1; i <= NUM_THREADS; i++)
		begin
			candidate = (int'(last_idx) + i) % NUM_THREADS;
			if (!found && request[candidate])
			begin
				search_oh[candidate] = 1'b1;
				search_idx = IDX_WIDTH'(candidate);
				found = 1'b1;
			end
		end
	end

	// A grant that was not taken last cycle stays put, even if a requester
	// closer to the pointer shows up in the meantime
	always_comb
	begin
		if (held && request[held_idx])
		begin
			grant_oh = '0;
			grant_oh[held_idx] = 1'b1;
			grant_idx = held_idx;
		end
		else
		begin
			grant_oh = search_oh;
			grant_idx = search_idx;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Thread 0 wins first after reset
			last_idx <= IDX_WIDTH'(NUM_THREADS - 1);
			held <= 1'b0;
			held_idx <= '0;
		end
		else if (advance)
		begin
			last_idx <= grant_idx;
			held <= 1'b0;
		end
		else
		begin
			held <= |grant_oh;
			held_idx <= grant_idx;
		end
	end

	assert property (@(posedge clk) disable iff (reset) $onehot0(grant_oh));

endmodule

`default_nettype wire

/* store_queue.sv */
// ######################################
// Per-thread store queue
// Write combining, rollback and wake,
// dequeue to the bridge and load bypass
// ######################################

`timescale 1ns/1ns
`default_nettype none

module store_queue #(
	parameter int NUM_THREADS = 4
) (
	input logic clk,
	input logic reset,
	input logic store_en,
	input logic membar_en,
	input logic [$clog2(NUM_THREADS) - 1:0] thread_idx,
	input sq_pkg::line_addr_u addr,
	input sq_pkg::byte_mask_t mask,
	input sq_pkg::line_data_t data,
	input logic [$clog2(NUM_THREADS) - 1:0] load_thread_idx,
	input sq_pkg::line_addr_u load_addr,
	output sq_pkg::byte_mask_t bypass_mask,
	output sq_pkg::line_data_t bypass_data,
	output logic rollback_en,
	output logic [NUM_THREADS - 1:0] wake_bitmap,
	output logic dequeue_ready,
	output logic [$clog2(NUM_THREADS) - 1:0] dequeue_idx,
	output sq_pkg::line_addr_u dequeue_addr,
	output sq_pkg::byte_mask_t dequeue_mask,
	output sq_pkg::line_data_t dequeue_data,
	input logic dequeue_ack,
	input logic response_valid,
	input logic [$clog2(NUM_THREADS) - 1:0] response_idx
);

	import sq_pkg::*;

	localparam int IDX_WIDTH = $clog2(NUM_THREADS);

	// Entry control state
	logic ent_valid [NUM_THREADS];
	logic ent_sent [NUM_THREADS];
	logic ent_waiting [NUM_THREADS];

	// Entry payload
	line_idx_t ent_line [NUM_THREADS];
	byte_mask_t ent_mask [NUM_THREADS];
	line_data_t ent_data [NUM_THREADS];

	logic [NUM_THREADS - 1:0] send_request;
	logic [NUM_THREADS - 1:0] grant_oh;
	logic [IDX_WIDTH - 1:0] grant_idx;
	logic [NUM_THREADS - 1:0] rollback;

	// Only entries that hold data and have not gone out yet compete
	rr_arbiter #(.NUM_THREADS(NUM_THREADS)) u_rr_arbiter (
		.clk(clk),
		.reset(reset),
		.request(send_request),
		.advance(dequeue_ack),
		.grant_oh(grant_oh),
		.grant_idx(grant_idx)
	);

	genvar t;
	generate
		for (t = 0; t < NUM_THREADS; t++)
		begin : g_entry
			logic store_hit;
			logic membar_hit;
			logic send_now;
			logic freed;
			logic can_combine;
			logic accept;

			assign store_hit = store_en && thread_idx == IDX_WIDTH'(t);
			assign membar_hit = membar_en && thread_idx == IDX_WIDTH'(t);
			assign send_now = grant_oh[t] && dequeue_ack;
			assign freed = response_valid && response_idx == IDX_WIDTH'(t);

			// Bytes may only merge while the bridge has not captured the line
			assign can_combine = ent_valid[t] && !ent_sent[t] && !send_now
				&& ent_line[t] == addr.fields.line_idx;

			// An entry completing this cycle makes room for the new store
			assign accept = store_hit && (!ent_valid[t] || freed || can_combine);

			assign rollback[t] = (store_hit && !accept)
				|| (membar_hit && ent_valid[t] && !freed);
			assign wake_bitmap[t] = freed && ent_waiting[t];
			assign send_request[t] = ent_valid[t] && !ent_sent[t];

			always_ff @(posedge clk, posedge reset)
			begin
				if (reset)
				begin
					ent_valid[t] <= 1'b0;
					ent_sent[t] <= 1'b0;
					ent_waiting[t] <= 1'b0;
				end
				else
				begin
					if (send_now)
						ent_sent[t] <= 1'b1;

					// A fresh store replaces a freed entry in the same cycle
					if (accept && !can_combine)
					begin
						ent_valid[t] <= 1'b1;
						ent_sent[t] <= 1'b0;
					end
					else if (freed)
						ent_valid[t] <= 1'b0;

					if (wake_bitmap[t])
						ent_waiting[t] <= 1'b0;
					else if (rollback[t])
						ent_waiting[t] <= 1'b1;
				end
			end

			always_ff @(posedge clk)
			begin
				if (accept)
				begin
					ent_line[t] <= addr.fields.line_idx;
					for (int b = 0; b < LINE_BYTES; b++)
					begin
						if (mask[b])
							ent_data[t][b * 8 +: 8] <= data[b * 8 +: 8];
					end

					if (can_combine)
						ent_mask[t] <= ent_mask[t] | mask;
					else
						ent_mask[t] <= mask;
				end
			end
		end
	endgenerate

	// Dequeue port shows the granted entry, line aligned
	assign dequeue_ready = |grant_oh;
	assign dequeue_idx = grant_idx;
	assign dequeue_addr.raw = {ent_line[grant_idx], {OFFSET_WIDTH{1'b0}}};
	assign dequeue_mask = ent_mask[grant_idx];
	assign dequeue_data = ent_data[grant_idx];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rollback_en <= 1'b0;
			bypass_mask <= '0;
		end
		else
		begin
			rollback_en <= |rollback;

			// A zero mask tells the merge stage to use the stored line only
			if (ent_valid[load_thread_idx]
				&& ent_line[load_thread_idx] == load_addr.fields.line_idx)
				bypass_mask <= ent_mask[load_thread_idx];
			else
				bypass_mask <= '0;
		end
	end

	// Data is only looked at under a nonzero mask
	always_ff @(posedge clk)
		bypass_data <= ent_data[load_thread_idx];

	assert property (@(posedge clk) disable iff (reset) !(store_en && membar_en));

	// The bridge may only answer for an entry it actually took
	assert property (@(posedge clk) disable iff (reset)
		response_valid |-> ent_valid[response_idx] && ent_sent[response_idx]);

	assert property (@(posedge clk) disable iff (reset) (wake_bitmap & rollback) == '0);

endmodule

`default_nettype wire

/* l2_bridge.sv */
// ######################################
// L2 bridge
// Four-phase memory handshake for one
// dequeued store, plus line store update
// ######################################

`timescale 1ns/1ns
`default_nettype none

module l2_bridge #(
	parameter int NUM_THREADS = 4
) (
	input logic clk,
	input logic reset,
	input logic dequeue_ready,
	input logic [$clog2(NUM_THREADS) - 1:0] dequeue_idx,
	input sq_pkg::line_addr_u dequeue_addr,
	input sq_pkg::byte_mask_t dequeue_mask,
	input sq_pkg::line_data_t dequeue_data,
	output logic dequeue_ack,
	output logic response_valid,
	output logic [$clog2(NUM_THREADS) - 1:0] response_idx,
	output logic mem_req,
	output sq_pkg::line_addr_u mem_addr,
	output sq_pkg::byte_mask_t mem_mask,
	output sq_pkg::line_data_t mem_data,
	input logic mem_ack,
	output logic wr_en,
	output sq_pkg::line_addr_u wr_addr,
	output sq_pkg::byte_mask_t wr_mask,
	output sq_pkg::line_data_t wr_data
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQUEST = 2'd1;
	localparam logic [1:0] ST_RELEASE = 2'd2;
	localparam logic [1:0] ST_RESPOND = 2'd3;

	logic [1:0] state;

	// Take a new entry only when the previous one has fully finished
	assign dequeue_ack = state == ST_IDLE && dequeue_ready;
	assign mem_req = state == ST_REQUEST;
	assign response_valid = state == ST_RESPOND;

	// The line store sees the same line on the acknowledging edge
	assign wr_en = state == ST_REQUEST && mem_ack;
	assign wr_addr = mem_addr;
	assign wr_mask = mem_mask;
	assign wr_data = mem_data;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (dequeue_ack)
						state <= ST_REQUEST;
				ST_REQUEST:
					if (mem_ack)
						state <= ST_RELEASE;
				// Wait for the far side to drop its acknowledge
				ST_RELEASE:
					if (!mem_ack)
						state <= ST_RESPOND;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Request payload is captured once and held through the handshake
	always_ff @(posedge clk)
	begin
		if (dequeue_ack)
		begin
			response_idx <= dequeue_idx;
			mem_addr <= dequeue_addr;
			mem_mask <= dequeue_mask;
			mem_data <= dequeue_data;
		end
	end

	assert property (@(posedge clk) disable iff (reset) $rose(mem_ack) |-> mem_req);

endmodule

`default_nettype wire

/* line_store.sv */
// ######################################
// Line store
// Small byte-writable line memory with a
// registered read port
// ######################################

`timescale 1ns/1ns
`default_nettype none

module line_store (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input sq_pkg::line_addr_u wr_addr,
	input sq_pkg::byte_mask_t wr_mask,
	input sq_pkg::line_data_t wr_data,
	input sq_pkg::line_addr_u rd_addr,
	output sq_pkg::line_data_t rd_data
);

	import sq_pkg::*;

	line_data_t lines [NUM_LINES];

	// Memory starts out as all zeros so the outside view is known
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_LINES; i++)
				lines[i] <= '0;
			rd_data <= '0;
		end
		else
		begin
			// Same-cycle read returns the line before this write lands
			rd_data <= lines[rd_addr.fields.line_idx];
			if (wr_en)
			begin
				for (int b = 0; b < LINE_BYTES; b++)
				begin
					if (wr_mask[b])
						lines[wr_addr.fields.line_idx][b * 8 +: 8] <= wr_data[b * 8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* load_merge.sv */
// ######################################
// Load merge stage
// Lays pending store bytes over the line
// read from the line store
// ######################################

`timescale 1ns/1ns
`default_nettype none

module load_merge (
	input logic clk,
	input logic reset,
	input logic load_en,
	input sq_pkg::line_data_t line_data,
	input sq_pkg::byte_mask_t bypass_mask,
	input sq_pkg::line_data_t bypass_data,
	output logic load_valid,
	output sq_pkg::line_data_t load_data
);

	import sq_pkg::*;

	// Marks the cycle in which both sources hold this load's results
	logic load_aligned;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			load_aligned <= 1'b0;
			load_valid <= 1'b0;
		end
		else
		begin
			load_aligned <= load_en;
			load_valid <= load_aligned;
		end
	end

	// Newer store bytes win over the stored copy
	always_ff @(posedge clk)
	begin
		if (load_aligned)
		begin
			for (int b = 0; b < LINE_BYTES; b++)
				load_data[b * 8 +: 8] <= bypass_mask[b] ? bypass_data[b * 8 +: 8]
					: line_data[b * 8 +: 8];
		end
	end

endmodule

`default_nettype wire

/* store_subsystem.sv */
// ######################################
// Store subsystem top level
// Store queue, L2 bridge, line store and
// load merge wired together
// ######################################

`timescale 1ns/1ns
`default_nettype none

module store_subsystem #(
	parameter int NUM_THREADS = 4
) (
	input logic clk,
	input logic reset,
	input logic store_en,
	input logic membar_en,
	input logic [$clog2(NUM_THREADS) - 1:0] thread_idx,
	input sq_pkg::line_addr_u addr,
	input sq_pkg::byte_mask_t mask,
	input sq_pkg::line_data_t data,
	input logic load_en,
	input logic [$clog2(NUM_THREADS) - 1:0] load_thread_idx,
	input sq_pkg::line_addr_u load_addr,
	output logic rollback_en,
	output logic [NUM_THREADS - 1:0] wake_bitmap,
	output logic load_valid,
	output sq_pkg::line_data_t load_data,
	output logic mem_req,
	output sq_pkg::line_addr_u mem_addr,
	output sq_pkg::byte_mask_t mem_mask,
	output sq_pkg::line_data_t mem_data,
	input logic mem_ack
);

	import sq_pkg::*;

	localparam int IDX_WIDTH = $clog2(NUM_THREADS);

	// Load path results from both sources
	byte_mask_t bypass_mask;
	line_data_t bypass_data;
	line_data_t line_data;

	// Queue to bridge
	logic dequeue_ready;
	logic [IDX_WIDTH - 1:0] dequeue_idx;
	line_addr_u dequeue_addr;
	byte_mask_t dequeue_mask;
	line_data_t dequeue_data;
	logic dequeue_ack;
	logic response_valid;
	logic [IDX_WIDTH - 1:0] response_idx;

	// Bridge to line store
	logic wr_en;
	line_addr_u wr_addr;
	byte_mask_t wr_mask;
	line_data_t wr_data;

	store_queue #(.NUM_THREADS(NUM_THREADS)) u_store_queue (
		.clk(clk),
		.reset(reset),
		.store_en(store_en),
		.membar_en(membar_en),
		.thread_idx(thread_idx),
		.addr(addr),
		.mask(mask),
		.data(data),
		.load_thread_idx(load_thread_idx),
		.load_addr(load_addr),
		.bypass_mask(bypass_mask),
		.bypass_data(bypass_data),
		.rollback_en(rollback_en),
		.wake_bitmap(wake_bitmap),
		.dequeue_ready(dequeue_ready),
		.dequeue_idx(dequeue_idx),
		.dequeue_addr(dequeue_addr),
		.dequeue_mask(dequeue_mask),
		.dequeue_data(dequeue_data),
		.dequeue_ack(dequeue_ack),
		.response_valid(response_valid),
		.response_idx(response_idx)
	);

	l2_bridge #(.NUM_THREADS(NUM_THREADS)) u_l2_bridge (
		.clk(clk),
		.reset(reset),
		.dequeue_ready(dequeue_ready),
		.dequeue_idx(dequeue_idx),
		.dequeue_addr(dequeue_addr),
		.dequeue_mask(dequeue_mask),
		.dequeue_data(dequeue_data),
		.dequeue_ack(dequeue_ack),
		.response_valid(response_valid),
		.response_idx(response_idx),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_mask(mem_mask),
		.mem_data(mem_data),
		.mem_ack(mem_ack),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_mask(wr_mask),
		.wr_data(wr_data)
	);

	// Both load sources look up the same address in the same cycle
	line_store u_line_store (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_mask(wr_mask),
		.wr_data(wr_data),
		.rd_addr(load_addr),
		.rd_data(line_data)
	);

	load_merge u_load_merge (
		.clk(clk),
		.reset(reset),
		.load_en(load_en),
		.line_data(line_data),
		.bypass_mask(bypass_mask),
		.bypass_data(bypass_data),
		.load_valid(load_valid),
		.load_data(load_data)
	);

endmodule

`default_nettype wire

/* tb_store_subsystem.sv */
// ######################################
// Store subsystem testbench
// Operation table, memory responder and
// reference models for stores and loads
// ######################################

`timescale 1ns/1ns
`default_nettype none

module tb_store_subsystem;

	import sq_pkg::*;

	localparam int NUM_THREADS = 4;
	localparam int OP_STORE = 0;
	localparam int OP_MEMBAR = 1;
	localparam int OP_LOAD = 2;
	localparam int OP_HOLD = 3;
	localparam int OP_RELEASE = 4;

	logic clk = 1'b0;
	logic reset;
	logic store_en;
	logic membar_en;
	logic [1:0] thread_idx;
	line_addr_u addr;
	byte_mask_t mask;
	line_data_t data;
	logic load_en;
	logic [1:0] load_thread_idx;
	line_addr_u load_addr;
	logic rollback_en;
	logic [NUM_THREADS - 1:0] wake_bitmap;
	logic load_valid;
	line_data_t load_data;
	logic mem_req;
	line_addr_u mem_addr;
	byte_mask_t mem_mask;
	line_data_t mem_data;
	logic mem_ack;

	// Operation table, one row applied per cycle
	int row_op [$];
	int row_thread [$];
	logic [7:0] row_addr [$];
	logic [7:0] row_mask [$];
	logic [63:0] row_data [$];
	logic row_rollback [$];

	// Reference model of the per-thread entries and of memory
	logic m_valid [NUM_THREADS];
	logic m_sent [NUM_THREADS];
	logic m_waiting [NUM_THREADS];
	logic [4:0] m_line [NUM_THREADS];
	logic [7:0] m_mask [NUM_THREADS];
	logic [63:0] m_data [NUM_THREADS];
	logic [63:0] mem_model [32];
	logic [NUM_THREADS - 1:0] woken;
	int last_winner;
	// Thread the arbiter is expected to hand to the bridge next, or -1
	int next_grant;

	// Responder and bookkeeping state
	integer seed;
	logic ack_hold;
	logic req_seen;
	logic req_pending;
	logic rollback_due;
	int ack_delay;
	int matched;
	int completed;
	int ticks;
	int cycle_count;
	int timeout_limit;
	logic [63:0] load_expect [$];
	int load_due [$];

	store_subsystem #(.NUM_THREADS(NUM_THREADS)) u_store_subsystem (
		.clk(clk),
		.reset(reset),
		.store_en(store_en),
		.membar_en(membar_en),
		.thread_idx(thread_idx),
		.addr(addr),
		.mask(mask),
		.data(data),
		.load_en(load_en),
		.load_thread_idx(load_thread_idx),
		.load_addr(load_addr),
		.rollback_en(rollback_en),
		.wake_bitmap(wake_bitmap),
		.load_valid(load_valid),
		.load_data(load_data),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_mask(mem_mask),
		.mem_data(mem_data),
		.mem_ack(mem_ack)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= timeout_limit)
		begin
			$display("Timeout: the run went past %0d cycles", timeout_limit);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_values(input string what, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
			abort_run();
		end
	endtask

	task automatic report_fault(input string reason);
		$display("%0t: %s", $time, reason);
		abort_run();
	endtask

	// Byte-wise overlay of new bytes onto an old line
	function automatic logic [63:0] merge_bytes(input logic [63:0] base,
		input logic [63:0] over, input logic [7:0] sel);
		logic [63:0] result;
		result = base;
		for (int b = 0; b < 8; b++)
		begin
			if (sel[b])
				result[b * 8 +: 8] = over[b * 8 +: 8];
		end
		return result;
	endfunction

	function automatic logic [NUM_THREADS - 1:0] waiting_bits();
		logic [NUM_THREADS - 1:0] bits;
		for (int t = 0; t < NUM_THREADS; t++)
			bits[t] = m_waiting[t];
		return bits;
	endfunction

	// Only masked bytes of a request carry meaning
	function automatic int find_request(input logic [4:0] line, input logic [7:0] mk,
		input logic [63:0] d);
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			if (m_valid[t] && !m_sent[t] && m_line[t] == line && m_mask[t] == mk
				&& merge_bytes('0, m_data[t], mk) == merge_bytes('0, d, mk))
				return t;
		end
		return -1;
	endfunction

	// First unsent entry after the last winner, wrapping
	function automatic int next_in_rotation();
		int c;
		for (int i = 1; i <= NUM_THREADS; i++)
		begin
			c = (last_winner + i) % NUM_THREADS;
			if (m_valid[c] && !m_sent[c])
				return c;
		end
		return -1;
	endfunction

	function automatic logic all_sent();
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			if (m_valid[t] && !m_sent[t])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// Checks and memory responder, run at every falling edge
	task automatic service_cycle();
		int t;
		compare_values("rollback_en", rollback_en, rollback_due);
		rollback_due = 1'b0;
		if ((wake_bitmap & ~waiting_bits()) != '0)
			report_fault("wake_bitmap named a thread that was never refused");
		woken = woken | wake_bitmap;

		// Loads come back after two register stages
		if (load_due.size() > 0 && load_due[0] == ticks)
		begin
			compare_values("load_valid", load_valid, 1'b1);
			compare_values("load_data", load_data, load_expect[0]);
			void'(load_due.pop_front());
			void'(load_expect.pop_front());
		end
		else
			compare_values("load_valid", load_valid, 1'b0);

		if (mem_req && !req_seen)
		begin
			compare_values("mem_ack at mem_req rise", mem_ack, 1'b0);
			compare_values("mem_addr offset", mem_addr.fields.offset, 0);
			t = find_request(mem_addr.fields.line_idx, mem_mask, mem_data);
			if (t < 0)
				report_fault("a memory request matches no pending store entry");
			else
			begin
				// A grant the bridge has not taken yet stays on the same thread
				compare_values("drain order thread", t, next_grant);
				m_sent[t] = 1'b1;
				last_winner = t;
				// Entries already waiting are picked in rotation after this winner
				next_grant = next_in_rotation();
				matched++;
				req_pending = 1'b1;
				ack_delay = 1 + ({$random(seed)} % 4);
			end
		end
		req_seen = mem_req;

		if (mem_ack)
		begin
			if (!mem_req)
			begin
				mem_ack = 1'b0;
				completed++;
			end
		end
		else if (req_pending && !ack_hold)
		begin
			if (ack_delay > 1)
				ack_delay--;
			else
			begin
				mem_ack = 1'b1;
				req_pending = 1'b0;
				mem_model[mem_addr.fields.line_idx] = merge_bytes(
					mem_model[mem_addr.fields.line_idx], mem_data, mem_mask);
			end
		end
	endtask

	task automatic tick();
		@(negedge clk);
		ticks++;
		service_cycle();
	endtask

	task automatic add_row(input int op, input int t, input logic [7:0] a,
		input logic [7:0] mk, input logic [63:0] d, input logic rb);
		row_op.push_back(op);
		row_thread.push_back(t);
		row_addr.push_back(a);
		row_mask.push_back(mk);
		row_data.push_back(d);
		row_rollback.push_back(rb);
	endtask

	// Stores are only issued while the queue is idle or acks are held back,
	// so no entry is ever freed in the same cycle as a new request
	task automatic build_table();
		// Lone stores, then loads of the merged line
		add_row(OP_STORE, 0, 8'h23, 8'h0f, 64'h1111_2222_3333_4444, 1'b0);
		add_row(OP_RELEASE, 0, 8'h00, 8'h00, 64'h0, 1'b0);
		add_row(OP_LOAD, 1, 8'h20, 8'h00, 64'h0, 1'b0);
		add_row(OP_STORE, 2, 8'h21, 8'hf0, 64'haaaa_bbbb_cccc_dddd, 1'b0);
		add_row(OP_RELEASE, 0, 8'h00, 8'h00, 64'h0, 1'b0);
		add_row(OP_LOAD, 0, 8'h27, 8'h00, 64'h0, 1'b0);
		// Thread 3 blocks the bridge while thread 1 combines and gets refused
		add_row(OP_HOLD, 0, 8'h00, 8'h00, 64'h0, 1'b0);
		add_row(OP_STORE, 3, 8'h40, 8'hff, 64'h0102_0304_0506_0708, 1'b0);
		add_row(OP_STORE, 1, 8'h21, 8'h03, 64'hdead_beef_0000_5566, 1'b0);
		add_row(OP_STORE, 1, 8'h22, 8'h06, 64'h0bad_f00d_0077_8800, 1'b0);
		add_row(OP_LOAD, 1, 8'h20, 8'h00, 64'h0, 1'b0);
		add_row(OP_LOAD, 2, 8'h20, 8'h00, 64'h0, 1'b0);
		add_row(OP_STORE, 1, 8'h60, 8'hff, 64'h1234_5678_9abc_def0, 1'b1);
		add_row(OP_MEMBAR, 1, 8'h00, 8'h00, 64'h0, 1'b1);
		add_row(OP_MEMBAR, 2, 8'h00, 8'h00, 64'h0, 1'b0);
		add_row(OP_STORE, 3, 8'h41, 8'h01, 64'h0000_0000_0000_00ee, 1'b1);
		add_row(OP_LOAD, 3, 8'h40, 8'h00, 64'h0, 1'b0);
		add_row(OP_RELEASE, 0, 8'h00, 8'h00, 64'h0, 1'b0);
		add_row(OP_LOAD, 0, 8'h20, 8'h00, 64'h0, 1'b0);
		// All four threads queue up and drain in rotation
		add_row(OP_HOLD, 0, 8'h00, 8'h00, 64'h0, 1'b0);
		add_row(OP_STORE, 2, 8'h80, 8'h01, 64'h0000_0000_0000_005a, 1'b0);
		add_row(OP_STORE, 0, 8'h88, 8'h80, 64'hc300_0000_0000_0000, 1'b0);
		add_row(OP_STORE, 3, 8'h90, 8'h3c, 64'h0000_1234_5678_0000, 1'b0);
		add_row(OP_STORE, 1, 8'h98, 8'hff, 64'h0f1e_2d3c_4b5a_6978, 1'b0);
		add_row(OP_RELEASE, 0, 8'h00, 8'h00, 64'h0, 1'b0);
		add_row(OP_LOAD, 0, 8'h80, 8'h00, 64'h0, 1'b0);
		add_row(OP_LOAD, 1, 8'h89, 8'h00, 64'h0, 1'b0);
		add_row(OP_LOAD, 2, 8'h93, 8'h00, 64'h0, 1'b0);
		add_row(OP_LOAD, 3, 8'h98, 8'h00, 64'h0, 1'b0);
		add_row(OP_MEMBAR, 0, 8'h00, 8'h00, 64'h0, 1'b0);
	endtask

	task automatic apply_store(input int t, input logic [7:0] a, input logic [7:0] mk,
		input logic [63:0] d, input logic expected_rb);
		line_addr_u la;
		logic refuse;
		la.raw = a;
		refuse = 1'b0;
		if (!m_valid[t])
		begin
			m_valid[t] = 1'b1;
			m_sent[t] = 1'b0;
			m_line[t] = la.fields.line_idx;
			m_mask[t] = mk;
			m_data[t] = merge_bytes(m_data[t], d, mk);
			// With nothing else pending the first new entry gets the grant
			if (next_grant < 0)
				next_grant = t;
		end
		else if (!m_sent[t] && m_line[t] == la.fields.line_idx)
		begin
			// Write combining, newest bytes win
			m_mask[t] = m_mask[t] | mk;
			m_data[t] = merge_bytes(m_data[t], d, mk);
		end
		else
		begin
			refuse = 1'b1;
			m_waiting[t] = 1'b1;
		end
		compare_values("model rollback against table", refuse, expected_rb);
		store_en = 1'b1;
		thread_idx = 2'(t);
		addr.raw = a;
		mask = mk;
		data = d;
		rollback_due = expected_rb;
	endtask

	task automatic apply_membar(input int t, input logic expected_rb);
		compare_values("model membar rollback against table", m_valid[t], expected_rb);
		if (m_valid[t])
			m_waiting[t] = 1'b1;
		membar_en = 1'b1;
		thread_idx = 2'(t);
		rollback_due = expected_rb;
	endtask

	task automatic apply_load(input int t, input logic [7:0] a);
		line_addr_u la;
		logic [63:0] expected;
		la.raw = a;
		expected = mem_model[la.fields.line_idx];
		if (m_valid[t] && m_line[t] == la.fields.line_idx)
			expected = merge_bytes(expected, m_data[t], m_mask[t]);
		load_en = 1'b1;
		load_thread_idx = 2'(t);
		load_addr.raw = a;
		load_expect.push_back(expected);
		load_due.push_back(ticks + 2);
	endtask

	// Let acks flow until every queued entry has finished its handshake
	task automatic drain_queue();
		ack_hold = 1'b0;
		while (!all_sent() || mem_req || mem_ack || completed != matched)
			tick();
		// Response and entry release follow the dropped ack
		repeat (3) tick();
		compare_values("threads woken", woken, waiting_bits());
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			m_valid[t] = 1'b0;
			m_sent[t] = 1'b0;
			m_waiting[t] = 1'b0;
		end
		woken = '0;
		next_grant = -1;
	endtask

	initial
	begin
		build_table();
		timeout_limit = 40 * row_op.size();
		cycle_count = 0;
		seed = 32'hc3079c0b;
		reset = 1'b1;
		store_en = 1'b0;
		membar_en = 1'b0;
		thread_idx = '0;
		addr = '0;
		mask = '0;
		data = '0;
		load_en = 1'b0;
		load_thread_idx = '0;
		load_addr = '0;
		mem_ack = 1'b0;
		ack_hold = 1'b0;
		req_seen = 1'b0;
		req_pending = 1'b0;
		rollback_due = 1'b0;
		ack_delay = 0;
		matched = 0;
		completed = 0;
		ticks = 0;
		woken = '0;
		last_winner = NUM_THREADS - 1;
		next_grant = -1;
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			m_valid[t] = 1'b0;
			m_sent[t] = 1'b0;
			m_waiting[t] = 1'b0;
			m_line[t] = '0;
			m_mask[t] = '0;
			m_data[t] = '0;
		end
		for (int i = 0; i < 32; i++)
			mem_model[i] = '0;

		repeat (4) @(negedge clk);
		reset = 1'b0;

		for (int r = 0; r < row_op.size(); r++)
		begin
			tick();
			store_en = 1'b0;
			membar_en = 1'b0;
			load_en = 1'b0;
			case (row_op[r])
				OP_STORE:
					apply_store(row_thread[r], row_addr[r], row_mask[r], row_data[r],
						row_rollback[r]);
				OP_MEMBAR:
					apply_membar(row_thread[r], row_rollback[r]);
				OP_LOAD:
					apply_load(row_thread[r], row_addr[r]);
				OP_HOLD:
					ack_hold = 1'b1;
				default:
					drain_queue();
			endcase
		end

		tick();
		store_en = 1'b0;
		membar_en = 1'b0;
		load_en = 1'b0;
		while (load_due.size() > 0)
			tick();
		repeat (2) tick();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
sq_pkg.sv
rr_arbiter.sv
store_queue.sv
l2_bridge.sv
line_store.sv
load_merge.sv
store_subsystem.sv
tb_store_subsystem.sv

/* Bender.yml */
package:
  name: store_subsystem

sources:
  - sq_pkg.sv
  - rr_arbiter.sv
  - store_queue.sv
  - l2_bridge.sv
  - line_store.sv
  - load_merge.sv
  - store_subsystem.sv
  - target: test
    files:
      - tb_store_subsystem.sv
